/* common/ex_pkg.sv */
package ex_pkg;

    localparam int DATA_W     = 32;        // gpr and hi/lo width
    localparam int REG_ADDR_W = 5;
    localparam int ALU_OP_W   = 8;

    // opcode codes
    localparam logic [ALU_OP_W-1:0] ALU_NOP_OP   = 8'h00;
    localparam logic [ALU_OP_W-1:0] ALU_OR_OP    = 8'h25;
    localparam logic [ALU_OP_W-1:0] ALU_AND_OP   = 8'h24;
    localparam logic [ALU_OP_W-1:0] ALU_XOR_OP   = 8'h26;
    localparam logic [ALU_OP_W-1:0] ALU_NOR_OP   = 8'h27;
    localparam logic [ALU_OP_W-1:0] ALU_SLL_OP   = 8'h7c;
    localparam logic [ALU_OP_W-1:0] ALU_SRL_OP   = 8'h02;
    localparam logic [ALU_OP_W-1:0] ALU_SRA_OP   = 8'h03;
    localparam logic [ALU_OP_W-1:0] ALU_MOVZ_OP  = 8'h0a;
    localparam logic [ALU_OP_W-1:0] ALU_MOVN_OP  = 8'h0b;
    localparam logic [ALU_OP_W-1:0] ALU_MFHI_OP  = 8'h10;
    localparam logic [ALU_OP_W-1:0] ALU_MTHI_OP  = 8'h11;
    localparam logic [ALU_OP_W-1:0] ALU_MFLO_OP  = 8'h12;
    localparam logic [ALU_OP_W-1:0] ALU_MTLO_OP  = 8'h13;
    localparam logic [ALU_OP_W-1:0] ALU_MULT_OP  = 8'h18;
    localparam logic [ALU_OP_W-1:0] ALU_MULTU_OP = 8'h19;
    localparam logic [ALU_OP_W-1:0] ALU_ADD_OP   = 8'h20;
    localparam logic [ALU_OP_W-1:0] ALU_ADDU_OP  = 8'h21;
    localparam logic [ALU_OP_W-1:0] ALU_SUB_OP   = 8'h22;
    localparam logic [ALU_OP_W-1:0] ALU_SUBU_OP  = 8'h23;
    localparam logic [ALU_OP_W-1:0] ALU_SLT_OP   = 8'h2a;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU_OP  = 8'h2b;
    localparam logic [ALU_OP_W-1:0] ALU_TGE_OP   = 8'h30;
    localparam logic [ALU_OP_W-1:0] ALU_TGEU_OP  = 8'h31;
    localparam logic [ALU_OP_W-1:0] ALU_TLT_OP   = 8'h32;
    localparam logic [ALU_OP_W-1:0] ALU_TLTU_OP  = 8'h33;
    localparam logic [ALU_OP_W-1:0] ALU_TEQ_OP   = 8'h34;
    localparam logic [ALU_OP_W-1:0] ALU_TNE_OP   = 8'h36;
    localparam logic [ALU_OP_W-1:0] ALU_MADD_OP  = 8'ha6;
    localparam logic [ALU_OP_W-1:0] ALU_MADDU_OP = 8'ha8;
    localparam logic [ALU_OP_W-1:0] ALU_MUL_OP   = 8'ha9;
    localparam logic [ALU_OP_W-1:0] ALU_MSUB_OP  = 8'haa;
    localparam logic [ALU_OP_W-1:0] ALU_MSUBU_OP = 8'hab;
    localparam logic [ALU_OP_W-1:0] ALU_CLZ_OP   = 8'hb0;
    localparam logic [ALU_OP_W-1:0] ALU_CLO_OP   = 8'hb1;

    // result classes
    localparam int RES_SEL_W = 3;
    localparam logic [RES_SEL_W-1:0] RES_NOP   = 3'b000;
    localparam logic [RES_SEL_W-1:0] RES_LOGIC = 3'b001;
    localparam logic [RES_SEL_W-1:0] RES_SHIFT = 3'b010;
    localparam logic [RES_SEL_W-1:0] RES_MOVE  = 3'b011;
    localparam logic [RES_SEL_W-1:0] RES_ARITH = 3'b100;

    localparam int HILO_OP_W = 3;
    localparam logic [HILO_OP_W-1:0] HILO_NONE = 3'd0;
    localparam logic [HILO_OP_W-1:0] HILO_MTHI = 3'd1;
    localparam logic [HILO_OP_W-1:0] HILO_MTLO = 3'd2;
    localparam logic [HILO_OP_W-1:0] HILO_MULT = 3'd3;
    localparam logic [HILO_OP_W-1:0] HILO_ACC  = 3'd4;     // madd/msub family

    localparam int TRAP_W = 3;
    localparam logic [TRAP_W-1:0] TRAP_NONE = 3'd0;
    localparam logic [TRAP_W-1:0] TRAP_EQ   = 3'd1;
    localparam logic [TRAP_W-1:0] TRAP_NE   = 3'd2;
    localparam logic [TRAP_W-1:0] TRAP_GE   = 3'd3;
    localparam logic [TRAP_W-1:0] TRAP_LT   = 3'd4;

endpackage

/* decode/ex_decode.sv */
`timescale 1ns/10ps

module ex_decode import ex_pkg::*; (
    input  logic [ALU_OP_W-1:0]  aluop_i,
    output logic [RES_SEL_W-1:0] res_sel_o,
    output logic                 signed_o,     // signed compare / product
    output logic                 sub_o,        // negate op2 in the adder
    output logic                 ovf_chk_o,
    output logic [HILO_OP_W-1:0] hilo_op_o,
    output logic [TRAP_W-1:0]    trap_cond_o
);

    always_comb begin
        res_sel_o   = RES_NOP;
        signed_o    = 1'b0;
        sub_o       = 1'b0;
        ovf_chk_o   = 1'b0;
        hilo_op_o   = HILO_NONE;
        trap_cond_o = TRAP_NONE;
        case (aluop_i)
            ALU_OR_OP, ALU_AND_OP, ALU_XOR_OP, ALU_NOR_OP: res_sel_o = RES_LOGIC;
            ALU_SLL_OP, ALU_SRL_OP, ALU_SRA_OP:            res_sel_o = RES_SHIFT;
            ALU_MOVN_OP, ALU_MOVZ_OP, ALU_MFHI_OP, ALU_MFLO_OP: begin
                res_sel_o = RES_MOVE;
            end
            ALU_ADD_OP: begin
                res_sel_o = RES_ARITH;
                signed_o  = 1'b1;
                ovf_chk_o = 1'b1;
            end
            ALU_SUB_OP: begin
                res_sel_o = RES_ARITH;
                signed_o  = 1'b1;
                sub_o     = 1'b1;
                ovf_chk_o = 1'b1;
            end
            ALU_SUBU_OP: begin
                res_sel_o = RES_ARITH;
                sub_o     = 1'b1;
            end
            ALU_SLT_OP: begin
                res_sel_o = RES_ARITH;
                signed_o  = 1'b1;
                sub_o     = 1'b1;
            end
            ALU_MUL_OP: begin
                res_sel_o = RES_ARITH;
                signed_o  = 1'b1;
            end
            ALU_ADDU_OP, ALU_SLTU_OP, ALU_CLZ_OP, ALU_CLO_OP: res_sel_o = RES_ARITH;
            ALU_MTHI_OP:  hilo_op_o = HILO_MTHI;
            ALU_MTLO_OP:  hilo_op_o = HILO_MTLO;
            ALU_MULTU_OP: hilo_op_o = HILO_MULT;
            ALU_MULT_OP: begin
                hilo_op_o = HILO_MULT;
                signed_o  = 1'b1;
            end
            ALU_MADDU_OP, ALU_MSUBU_OP: hilo_op_o = HILO_ACC;
            ALU_MADD_OP, ALU_MSUB_OP: begin
                hilo_op_o = HILO_ACC;
                signed_o  = 1'b1;
            end
            ALU_TEQ_OP:  trap_cond_o = TRAP_EQ;
            ALU_TNE_OP:  trap_cond_o = TRAP_NE;
            ALU_TGEU_OP: trap_cond_o = TRAP_GE;
            ALU_TLTU_OP: trap_cond_o = TRAP_LT;
            ALU_TGE_OP, ALU_TLT_OP: begin
                trap_cond_o = (aluop_i == ALU_TGE_OP) ? TRAP_GE : TRAP_LT;
                signed_o    = 1'b1;
                sub_o       = 1'b1;                // signed lt needs the difference
            end
            default: ;
        endcase
    end

    // overflow only makes sense on an adder result that gets written back
    always_comb begin
        assert final (!ovf_chk_o || res_sel_o == RES_ARITH);
    end

endmodule

/* execute/alu_exec.sv */
`timescale 1ns/10ps

module alu_exec import ex_pkg::*; (
    input  logic [ALU_OP_W-1:0] aluop_i,
    input  logic [DATA_W-1:0]   op1_i,
    input  logic [DATA_W-1:0]   op2_i,
    input  logic [DATA_W-1:0]   hi_i,
    input  logic [DATA_W-1:0]   lo_i,
    input  logic                signed_i,
    input  logic                sub_i,
    input  logic                ovf_chk_i,
    input  logic [TRAP_W-1:0]   trap_cond_i,
    output logic [DATA_W-1:0]   logic_res_o,
    output logic [DATA_W-1:0]   shift_res_o,
    output logic [DATA_W-1:0]   move_res_o,
    output logic [DATA_W-1:0]   arith_res_o,
    output logic                ovf_o,
    output logic                trap_o
);

    logic [4:0]        shamt;
    logic [DATA_W-1:0] op2_mux;
    logic [DATA_W-1:0] sum;
    logic              op1_sign, op2_sign_eff, sum_sign;
    logic              lt_signed, op1_lt_op2, op1_eq_op2;
    logic [5:0]        lead_cnt;
    logic              count_ones;

    assign shamt   = op2_i[4:0];
    assign op2_mux = sub_i ? (~op2_i + 1'b1) : op2_i;      // shared adder input
    assign sum     = op1_i + op2_mux;

    assign op1_sign     = op1_i[DATA_W-1];
    assign op2_sign_eff = op2_i[DATA_W-1] ^ sub_i;           // sign as the adder sees it
    assign sum_sign     = sum[DATA_W-1];
    assign ovf_o = ovf_chk_i & ((~op1_sign & ~op2_sign_eff & sum_sign) |
                                (op1_sign & op2_sign_eff & ~sum_sign));

    // sum sign alone is wrong when the difference overflows
    assign lt_signed = (op1_sign & ~op2_i[DATA_W-1]) |
                       (~(op1_sign ^ op2_i[DATA_W-1]) & sum_sign);
    assign op1_lt_op2 = signed_i ? lt_signed : (op1_i < op2_i);
    assign op1_eq_op2 = (op1_i == op2_i);

    always_comb begin
        case (trap_cond_i)
            TRAP_EQ: trap_o = op1_eq_op2;
            TRAP_NE: trap_o = ~op1_eq_op2;
            TRAP_GE: trap_o = ~op1_lt_op2;
            TRAP_LT: trap_o = op1_lt_op2;
            default: trap_o = 1'b0;
        endcase
    end

    assign count_ones = (aluop_i == ALU_CLO_OP);

    // highest bit that breaks the run wins
    always_comb begin
        lead_cnt = 6'd32;
        for (int i = 0; i < DATA_W; i++) begin
            if (op1_i[i] ^ count_ones) lead_cnt = 6'(DATA_W - 1 - i);
        end
    end

    always_comb begin
        logic_res_o = '0;
        shift_res_o = '0;
        move_res_o  = '0;
        arith_res_o = '0;
        case (aluop_i)
            ALU_OR_OP:   logic_res_o = op1_i | op2_i;
            ALU_AND_OP:  logic_res_o = op1_i & op2_i;
            ALU_XOR_OP:  logic_res_o = op1_i ^ op2_i;
            ALU_NOR_OP:  logic_res_o = ~(op1_i | op2_i);
            ALU_SLL_OP:  shift_res_o = op1_i << shamt;
            ALU_SRL_OP:  shift_res_o = op1_i >> shamt;
            ALU_SRA_OP:  shift_res_o = $signed(op1_i) >>> shamt;
            ALU_MOVN_OP, ALU_MOVZ_OP: move_res_o = op1_i;   // condition checked upstream
            ALU_MFHI_OP: move_res_o = hi_i;
            ALU_MFLO_OP: move_res_o = lo_i;
            ALU_ADD_OP, ALU_ADDU_OP, ALU_SUB_OP, ALU_SUBU_OP: arith_res_o = sum;
            ALU_SLT_OP, ALU_SLTU_OP: arith_res_o = {{(DATA_W-1){1'b0}}, op1_lt_op2};
            ALU_MUL_OP:  arith_res_o = op1_i * op2_i;       // low word is the same either sign
            ALU_CLZ_OP, ALU_CLO_OP: arith_res_o = {{(DATA_W-6){1'b0}}, lead_cnt};
            default: ;
        endcase
    end

endmodule

/* execute/hilo_unit.sv */
`timescale 1ns/10ps

module hilo_unit import ex_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 valid_i,
    input  logic [ALU_OP_W-1:0]  aluop_i,
    input  logic [HILO_OP_W-1:0] hilo_op_i,
    input  logic                 signed_i,
    input  logic [DATA_W-1:0]    op1_i,
    input  logic [DATA_W-1:0]    op2_i,
    output logic [DATA_W-1:0]    hi_o,
    output logic [DATA_W-1:0]    lo_o,
    output logic                 stall_o
);

    logic signed [2*DATA_W-1:0] prod_s;
    logic [2*DATA_W-1:0]        prod_u;
    logic [2*DATA_W-1:0]        prod;
    logic [2*DATA_W-1:0]        acc_prod;     // product held across the stall
    logic [2*DATA_W-1:0]        acc_sum;
    logic                       acc_phase;    // second cycle of madd/msub
    logic                       acc_sub;
    logic                       is_acc;
    logic                       accept;

    assign prod_s = $signed(op1_i) * $signed(op2_i);
    assign prod_u = op1_i * op2_i;
    assign prod   = signed_i ? prod_s : prod_u;

    assign is_acc  = valid_i && (hilo_op_i == HILO_ACC);
    assign stall_o = is_acc && !acc_phase;
    assign accept  = valid_i && !stall_o;

    assign acc_sub = (aluop_i == ALU_MSUB_OP) || (aluop_i == ALU_MSUBU_OP);
    assign acc_sum = acc_sub ? ({hi_o, lo_o} - acc_prod) : ({hi_o, lo_o} + acc_prod);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            acc_phase <= 1'b0;
        end else if (stall_o) begin
            acc_phase <= 1'b1;
        end else if (accept) begin
            acc_phase <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (stall_o) acc_prod <= prod;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            hi_o <= '0;
            lo_o <= '0;
        end else if (accept) begin
            case (hilo_op_i)
                HILO_MTHI: hi_o <= op1_i;
                HILO_MTLO: lo_o <= op1_i;
                HILO_MULT: {hi_o, lo_o} <= prod;
                HILO_ACC:  {hi_o, lo_o} <= acc_sum;
                default: ;
            endcase
        end
    end

    // stall only ever comes from a presented accumulate op
    a_stall_src: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_o |-> valid_i && (hilo_op_i == HILO_ACC));

    // held inputs must get through after one stalled cycle
    a_stall_once: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_o ##1 (valid_i && $stable(aluop_i) && $stable(op1_i) && $stable(op2_i))
        |-> !stall_o);

endmodule

/* result/ex_result.sv */
`timescale 1ns/10ps

module ex_result import ex_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  accept_i,
    input  logic [RES_SEL_W-1:0]  res_sel_i,
    input  logic [DATA_W-1:0]     logic_res_i,
    input  logic [DATA_W-1:0]     shift_res_i,
    input  logic [DATA_W-1:0]     move_res_i,
    input  logic [DATA_W-1:0]     arith_res_i,
    input  logic                  ovf_i,
    input  logic                  trap_i,
    input  logic [REG_ADDR_W-1:0] waddr_i,
    input  logic                  reg_we_i,
    output logic                  valid_o,
    output logic [REG_ADDR_W-1:0] waddr_o,
    output logic                  reg_we_o,
    output logic [DATA_W-1:0]     result_o,
    output logic                  ov_exc_o,
    output logic                  trap_exc_o
);

    logic [DATA_W-1:0] sel_res;

    always_comb begin
        case (res_sel_i)
            RES_LOGIC: sel_res = logic_res_i;
            RES_SHIFT: sel_res = shift_res_i;
            RES_MOVE:  sel_res = move_res_i;
            RES_ARITH: sel_res = arith_res_i;
            default:   sel_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_o    <= 1'b0;
            reg_we_o   <= 1'b0;
            ov_exc_o   <= 1'b0;
            trap_exc_o <= 1'b0;
            result_o   <= '0;
        end else begin
            valid_o    <= accept_i;
            reg_we_o   <= accept_i && reg_we_i && !ovf_i;    // overflow kills the write
            ov_exc_o   <= accept_i && ovf_i;
            trap_exc_o <= accept_i && trap_i;
            if (accept_i) result_o <= sel_res;
        end
    end

    always_ff @(posedge clk) begin
        if (accept_i) waddr_o <= waddr_i;
    end

    a_no_ovf_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(reg_we_o && ov_exc_o));

endmodule

/* source/ex_stage.sv */
`timescale 1ns/10ps

module ex_stage import ex_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  valid_i,
    input  logic [ALU_OP_W-1:0]   aluop_i,
    input  logic [DATA_W-1:0]     op1_i,
    input  logic [DATA_W-1:0]     op2_i,
    input  logic [REG_ADDR_W-1:0] waddr_i,
    input  logic                  reg_we_i,
    output logic                  valid_o,
    output logic [REG_ADDR_W-1:0] waddr_o,
    output logic                  reg_we_o,
    output logic [DATA_W-1:0]     result_o,
    output logic [DATA_W-1:0]     hi_o,
    output logic [DATA_W-1:0]     lo_o,
    output logic                  ov_exc_o,
    output logic                  trap_exc_o,
    output logic                  stall_o
);

    logic [RES_SEL_W-1:0] res_sel;
    logic                 is_signed, is_sub, ovf_chk;
    logic [HILO_OP_W-1:0] hilo_op;
    logic [TRAP_W-1:0]    trap_cond;
    logic [DATA_W-1:0]    logic_res, shift_res, move_res, arith_res;
    logic                 ovf, trap;
    logic                 accept;

    assign accept = valid_i && !stall_o;    // held inputs retire when stall drops

    ex_decode u_decode (
        .aluop_i    (aluop_i),   .res_sel_o (res_sel),  .signed_o   (is_signed),
        .sub_o      (is_sub),    .ovf_chk_o (ovf_chk),  .hilo_op_o  (hilo_op),
        .trap_cond_o(trap_cond)
    );

    alu_exec u_alu (
        .aluop_i    (aluop_i),   .op1_i      (op1_i),     .op2_i     (op2_i),
        .hi_i       (hi_o),      .lo_i       (lo_o),      .signed_i  (is_signed),
        .sub_i      (is_sub),    .ovf_chk_i  (ovf_chk),   .trap_cond_i(trap_cond),
        .logic_res_o(logic_res), .shift_res_o(shift_res), .move_res_o(move_res),
        .arith_res_o(arith_res), .ovf_o      (ovf),       .trap_o    (trap)
    );

    hilo_unit u_hilo (
        .clk      (clk),      .rst_n_i  (rst_n_i),   .valid_i (valid_i),
        .aluop_i  (aluop_i),  .hilo_op_i(hilo_op),   .signed_i(is_signed),
        .op1_i    (op1_i),    .op2_i    (op2_i),     .hi_o    (hi_o),
        .lo_o     (lo_o),     .stall_o  (stall_o)
    );

    ex_result u_result (
        .clk        (clk),        .rst_n_i    (rst_n_i),   .accept_i   (accept),
        .res_sel_i  (res_sel),    .logic_res_i(logic_res), .shift_res_i(shift_res),
        .move_res_i (move_res),   .arith_res_i(arith_res), .ovf_i      (ovf),
        .trap_i     (trap),       .waddr_i    (waddr_i),   .reg_we_i   (reg_we_i),
        .valid_o    (valid_o),    .waddr_o    (waddr_o),   .reg_we_o   (reg_we_o),
        .result_o   (result_o),   .ov_exc_o   (ov_exc_o),  .trap_exc_o (trap_exc_o)
    );

endmodule

/* sim/ex_tests.svh */
task automatic reset_values();
    begin_test("reset_values");
    check_val("flags", 5'b0, {valid_o, reg_we_o, ov_exc_o, trap_exc_o, stall_o});
    check_val("hi/lo", 64'd0, {hi_o, lo_o});
    check_val("result_o", 32'd0, result_o);
    end_test();
endtask

task automatic random_alu_ops();
    logic [ALU_OP_W-1:0] ops [12] = '{ALU_OR_OP, ALU_AND_OP, ALU_XOR_OP, ALU_NOR_OP,
        ALU_SLL_OP, ALU_SRL_OP, ALU_SRA_OP, ALU_ADDU_OP, ALU_SUBU_OP, ALU_MUL_OP,
        ALU_SLTU_OP, ALU_SLT_OP};
    logic [31:0] a, b, r;
    begin_test("random_alu_ops");
    for (int i = 0; i < 36; i++) begin
        a = lcg_next();
        b = lcg_next();
        r = lcg_next();
        do_op(ops[i % 12], a, b, r[31], r[30:26]);     // upper lcg bits for we/addr
    end
    end_test();
endtask

task automatic count_and_move();
    logic [31:0] vals [7] = '{32'h0, 32'hffffffff, 32'h1, 32'h80000000,
                              32'h00010000, 32'hfffeffff, 32'h7fffffff};
    begin_test("count_and_move");
    foreach (vals[i]) begin
        do_op(ALU_CLZ_OP, vals[i], 32'h0, 1'b1, 5'd3);
        do_op(ALU_CLO_OP, vals[i], 32'h0, 1'b1, 5'd4);
    end
    do_op(ALU_MOVN_OP, 32'h1234abcd, 32'h1, 1'b1, 5'd7);
    do_op(ALU_MOVZ_OP, 32'hcafe0001, 32'h0, 1'b1, 5'd8);
    end_test();
endtask

task automatic overflow_and_traps();
    logic [ALU_OP_W-1:0] traps [6] = '{ALU_TEQ_OP, ALU_TNE_OP, ALU_TGE_OP,
                                       ALU_TGEU_OP, ALU_TLT_OP, ALU_TLTU_OP};
    logic [31:0] pa [3] = '{32'h5, 32'hfffffffd, 32'h7};   // equal, less, greater (signed)
    logic [31:0] pb [3] = '{32'h5, 32'h7, 32'hfffffffd};
    begin_test("overflow_and_traps");
    do_op(ALU_ADD_OP, 32'h7fffffff, 32'h1, 1'b1, 5'd1);          // positive wrap
    do_op(ALU_ADD_OP, 32'h80000000, 32'h80000000, 1'b1, 5'd2);
    do_op(ALU_ADD_OP, 32'hfffffff0, 32'h20, 1'b1, 5'd3);
    do_op(ALU_SUB_OP, 32'h80000000, 32'h1, 1'b1, 5'd4);
    do_op(ALU_SUB_OP, 32'h7fffffff, 32'hffffffff, 1'b1, 5'd5);
    do_op(ALU_SUB_OP, 32'h5, 32'h9, 1'b1, 5'd6);
    foreach (traps[i])
        foreach (pa[j])
            do_op(traps[i], pa[j], pb[j], 1'b0, 5'd0);
    end_test();
endtask

task automatic hilo_writes();
    logic [ALU_OP_W-1:0] muls [2] = '{ALU_MULT_OP, ALU_MULTU_OP};
    begin_test("hilo_writes");
    do_op(ALU_MTHI_OP, 32'h13579bdf, 32'h0, 1'b0, 5'd0);
    do_op(ALU_MTLO_OP, 32'h2468ace0, 32'h0, 1'b0, 5'd0);
    do_op(ALU_MFHI_OP, 32'h0, 32'h0, 1'b1, 5'd10);
    do_op(ALU_MFLO_OP, 32'h0, 32'h0, 1'b1, 5'd11);
    foreach (muls[i]) begin
        do_op(muls[i], 32'hfffff000, 32'h00123456, 1'b0, 5'd0);
        do_op(ALU_MFHI_OP, 32'h0, 32'h0, 1'b1, 5'd12);
        do_op(ALU_MFLO_OP, 32'h0, 32'h0, 1'b1, 5'd13);
    end
    end_test();
endtask

task automatic accumulate_ops();
    logic [ALU_OP_W-1:0] accs [4] = '{ALU_MADD_OP, ALU_MADDU_OP, ALU_MSUB_OP, ALU_MSUBU_OP};
    begin_test("accumulate_ops");
    foreach (accs[i]) begin
        do_op(ALU_MTHI_OP, 32'h00000010 + i, 32'h0, 1'b0, 5'd0);   // known start value
        do_op(ALU_MTLO_OP, 32'hfffffff0, 32'h0, 1'b0, 5'd0);
        do_op(accs[i], 32'h80000003, 32'h7ffffff1, 1'b0, 5'd0);
    end
    end_test();
endtask

/* sim/tb_ex_stage.sv */
`timescale 1ns/10ps

module tb_ex_stage import ex_pkg::*; ();

    localparam int WAIT_LIMIT = 8;                 // cycles before a wait gives up

    logic                  clk, rst_n_i, valid_i, reg_we_i;
    logic [ALU_OP_W-1:0]   aluop_i;
    logic [DATA_W-1:0]     op1_i, op2_i;
    logic [REG_ADDR_W-1:0] waddr_i;
    logic                  valid_o, reg_we_o, ov_exc_o, trap_exc_o, stall_o;
    logic [REG_ADDR_W-1:0] waddr_o;
    logic [DATA_W-1:0]     result_o, hi_o, lo_o;

    int                errors, test_errs, n_pass, n_fail;
    string             cur_test;
    logic [31:0]       lcg_state;
    logic [DATA_W-1:0] exp_hi, exp_lo;             // hi/lo as the model tracks them

    ex_stage i_dut (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [DATA_W-1:0] count_lead(input logic [DATA_W-1:0] v,
                                                     input logic bit_val);
        int n;
        n = 0;
        while (n < DATA_W && v[DATA_W-1-n] == bit_val) n++;
        return n;
    endfunction

    function automatic logic [DATA_W-1:0] model_result(input logic [ALU_OP_W-1:0] op,
                                                       input logic [DATA_W-1:0] a, b);
        case (op)
            ALU_OR_OP:               return a | b;
            ALU_AND_OP:              return a & b;
            ALU_XOR_OP:              return a ^ b;
            ALU_NOR_OP:              return ~(a | b);
            ALU_SLL_OP:              return a << b[4:0];
            ALU_SRL_OP:              return a >> b[4:0];
            ALU_SRA_OP:              return $signed(a) >>> b[4:0];
            ALU_MOVN_OP, ALU_MOVZ_OP: return a;
            ALU_MFHI_OP:             return exp_hi;
            ALU_MFLO_OP:             return exp_lo;
            ALU_ADD_OP, ALU_ADDU_OP: return a + b;
            ALU_SUB_OP, ALU_SUBU_OP: return a - b;
            ALU_MUL_OP:              return a * b;  // low word of the product
            ALU_SLT_OP:              return $signed(a) < $signed(b);
            ALU_SLTU_OP:             return a < b;
            ALU_CLZ_OP, ALU_CLO_OP:  return count_lead(a, op == ALU_CLO_OP);
            default:                 return '0;
        endcase
    endfunction

    function automatic logic model_ovf(input logic [ALU_OP_W-1:0] op,
                                       input logic [DATA_W-1:0] a, b);
        longint s;
        if (op == ALU_ADD_OP) s = longint'($signed(a)) + longint'($signed(b));
        else if (op == ALU_SUB_OP) s = longint'($signed(a)) - longint'($signed(b));
        else return 1'b0;
        return s != longint'($signed(s[31:0]));    // exact sum does not fit 32 bits
    endfunction

    function automatic logic model_trap(input logic [ALU_OP_W-1:0] op,
                                        input logic [DATA_W-1:0] a, b);
        case (op)
            ALU_TEQ_OP:  return a == b;
            ALU_TNE_OP:  return a != b;
            ALU_TGE_OP:  return $signed(a) >= $signed(b);
            ALU_TGEU_OP: return a >= b;
            ALU_TLT_OP:  return $signed(a) < $signed(b);
            ALU_TLTU_OP: return a < b;
            default:     return 1'b0;
        endcase
    endfunction

    function automatic void update_hilo(input logic [ALU_OP_W-1:0] op,
                                        input logic [DATA_W-1:0] a, b);
        logic [63:0] sp, up, hl;
        sp = longint'($signed(a)) * longint'($signed(b));
        up = {32'd0, a} * {32'd0, b};
        hl = {exp_hi, exp_lo};
        case (op)
            ALU_MTHI_OP:  hl[63:32] = a;
            ALU_MTLO_OP:  hl[31:0] = a;
            ALU_MULT_OP:  hl = sp;
            ALU_MULTU_OP: hl = up;
            ALU_MADD_OP:  hl = hl + sp;
            ALU_MADDU_OP: hl = hl + up;
            ALU_MSUB_OP:  hl = hl - sp;
            ALU_MSUBU_OP: hl = hl - up;
            default: ;
        endcase
        {exp_hi, exp_lo} = hl;
    endfunction

    task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("Mismatch in %s (%s): expected %h, actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_errs = errors;
    endtask

    task automatic end_test();
        if (errors == test_errs) begin
            $display("%s: ok", cur_test);
            n_pass++;
        end else begin
            $display("%s: failed with %0d errors", cur_test, errors - test_errs);
            n_fail++;
        end
    endtask

    // one instruction from presentation to retirement, checked against the model
    task automatic do_op(input logic [ALU_OP_W-1:0] op, input logic [DATA_W-1:0] a, b,
                         input logic we, input logic [REG_ADDR_W-1:0] wa);
        logic [DATA_W-1:0] exp_res;
        logic              exp_ovf, exp_trap, is_acc;
        int                cycles, stalls;
        exp_res  = model_result(op, a, b);
        exp_ovf  = model_ovf(op, a, b);
        exp_trap = model_trap(op, a, b);
        is_acc   = (op == ALU_MADD_OP) || (op == ALU_MADDU_OP) ||
                   (op == ALU_MSUB_OP) || (op == ALU_MSUBU_OP);
        update_hilo(op, a, b);
        @(posedge clk);
        #2;
        valid_i  = 1'b1;
        aluop_i  = op;
        op1_i    = a;
        op2_i    = b;
        reg_we_i = we;
        waddr_i  = wa;
        #1;
        stalls = stall_o;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
            if (!valid_o) stalls += stall_o;
        end while (!valid_o && cycles < WAIT_LIMIT);
        if (!valid_o) begin
            $display("%s: valid_o never rose within %0d cycles for opcode %h",
                     cur_test, WAIT_LIMIT, op);
            errors++;
        end
        check_val("result_o", exp_res, result_o);
        check_val("waddr_o", wa, waddr_o);
        check_val("reg_we_o", we && !exp_ovf, reg_we_o);
        check_val("ov_exc_o", exp_ovf, ov_exc_o);
        check_val("trap_exc_o", exp_trap, trap_exc_o);
        check_val("hi/lo", {exp_hi, exp_lo}, {hi_o, lo_o});
        check_val("stall cycles", is_acc, stalls);
        #1;
        valid_i = 1'b0;
        @(posedge clk);
        #1;
        if (valid_o) begin
            $display("%s: valid_o stayed high a second cycle for opcode %h", cur_test, op);
            errors++;
        end
    endtask

    `include "ex_tests.svh"

    initial begin
        clk       = 1'b0;
        rst_n_i   = 1'b0;
        valid_i   = 1'b0;
        reg_we_i  = 1'b0;
        aluop_i   = ALU_NOP_OP;
        op1_i     = '0;
        op2_i     = '0;
        waddr_i   = '0;
        errors    = 0;
        n_pass    = 0;
        n_fail    = 0;
        lcg_state = 32'haeac73a4;
        exp_hi    = '0;
        exp_lo    = '0;
        repeat (4) @(posedge clk);
        #2;
        rst_n_i = 1'b1;
        reset_values();
        random_alu_ops();
        count_and_move();
        overflow_and_traps();
        hilo_writes();
        accumulate_ops();
        $display("tests ok: %0d, tests with errors: %0d", n_pass, n_fail);
        if (errors == 0 && n_fail == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

/* build.f */
+incdir+sim
common/ex_pkg.sv
decode/ex_decode.sv
execute/alu_exec.sv
execute/hilo_unit.sv
result/ex_result.sv
source/ex_stage.sv
sim/tb_ex_stage.sv
